//--- hw/pcs_10g_loopback.sv
// 10GBASE-R PCS loopback top level for board tests.
// receive path feeds the transmit path through one word register.
// also holds the delayed reset for the transmit side.

`timescale 1ns/1ps

module pcs_10g_loopback
	import pcs_line_pkg::*;
	import pcs_word_pkg::*;
(
	input  logic       tx_par_clk,
	input  logic       nreset,
	input  logic       rx_locked_i,
	input  pcs_block_t rx_par_data_i,
	output logic       rx_block_lock_o,
	output pcs_block_t tx_par_data_o
);

pcs_word_t rx_word;
pcs_word_t tx_word;
logic      tx_nreset_q1;
logic      tx_nreset_q2;
logic      tx_nreset;

pcs_rx u_pcs_rx (
	.tx_par_clk     (tx_par_clk),
	.nreset         (nreset),
	.serdes_lock_i  (rx_locked_i),
	.serdes_block_i (rx_par_data_i),
	.lock_o         (rx_block_lock_o),
	.word_o         (rx_word)
);

// ******************************
// loopback stage
// ******************************
// the tx side leaves reset three cycles after nreset rises.
always_ff @(posedge tx_par_clk) begin
	if (!nreset) begin
		tx_nreset_q1 <= 1'b0;
		tx_nreset_q2 <= 1'b0;
		tx_nreset    <= 1'b0;
	end else begin
		tx_nreset_q1 <= 1'b1;
		tx_nreset_q2 <= tx_nreset_q1;
		tx_nreset    <= tx_nreset_q2;
	end
end

always_ff @(posedge tx_par_clk) begin
	if (!nreset)
		tx_word <= WORD_IDLE;
	else
		tx_word <= rx_word;
end

pcs_tx u_pcs_tx (
	.tx_par_clk     (tx_par_clk),
	.nreset         (tx_nreset),
	.word_i         (tx_word),
	.serdes_block_o (tx_par_data_o)
);

endmodule

//--- hw/pcs_block_lock.sv
// sync header checker for the receive path.
// counts valid headers to gain block lock and bad headers per window to lose it.

`timescale 1ns/1ps

module pcs_block_lock
	import pcs_line_pkg::*;
(
	input  logic       tx_par_clk,
	input  logic       nreset,
	input  logic       serdes_lock_i,
	input  pcs_block_t block_i,
	output logic       hdr_ok_o,
	output logic       lock_o
);

typedef enum logic {ST_HUNT, ST_LOCKED} lock_state_e;

lock_state_e            state_q;
logic [LOCK_GOOD_W-1:0] good_cnt_q;
logic [LOCK_BAD_W-1:0]  bad_cnt_q;
logic [LOCK_WIN_W-1:0]  win_cnt_q;
logic                   hdr_ok_q;
logic                   hdr_valid;

assign hdr_valid = (block_i.sync == SYNC_DATA) || (block_i.sync == SYNC_CTRL);

always_ff @(posedge tx_par_clk) begin
	if (!nreset || !serdes_lock_i) begin
		state_q    <= ST_HUNT;
		good_cnt_q <= '0;
		bad_cnt_q  <= '0;
		win_cnt_q  <= '0;
		hdr_ok_q   <= 1'b0;
	end else begin
		hdr_ok_q <= hdr_valid;
		case (state_q)
			ST_HUNT: begin
				// any bad header restarts the search.
				if (!hdr_valid) begin
					good_cnt_q <= '0;
				end else if (good_cnt_q == LOCK_GOOD_W'(LOCK_GOOD_CNT - 1)) begin
					state_q    <= ST_LOCKED;
					good_cnt_q <= '0;
					bad_cnt_q  <= '0;
					win_cnt_q  <= '0;
				end else begin
					good_cnt_q <= good_cnt_q + 1'b1;
				end
			end
			ST_LOCKED: begin
				// the current block still belongs to the window it closes.
				if (!hdr_valid && bad_cnt_q == LOCK_BAD_W'(LOCK_BAD_CNT - 1)) begin
					state_q   <= ST_HUNT;
					bad_cnt_q <= '0;
					win_cnt_q <= '0;
				end else if (win_cnt_q == LOCK_WIN_W'(LOCK_WIN - 1)) begin
					bad_cnt_q <= '0;
					win_cnt_q <= '0;
				end else begin
					win_cnt_q <= win_cnt_q + 1'b1;
					if (!hdr_valid)
						bad_cnt_q <= bad_cnt_q + 1'b1;
				end
			end
			default: state_q <= ST_HUNT;
		endcase
	end
end

assign hdr_ok_o = hdr_ok_q;
assign lock_o   = (state_q == ST_LOCKED);

endmodule

//--- hw/pcs_decoder.sv
// block decoder for the receive path.
// turns a descrambled block plus lock and header status into a client word.

`timescale 1ns/1ps

module pcs_decoder
	import pcs_line_pkg::*;
	import pcs_word_pkg::*;
(
	input  logic       tx_par_clk,
	input  logic       nreset,
	input  logic       lock_i,
	input  logic       hdr_ok_i,
	input  pcs_block_t block_i,
	output pcs_word_t  word_o
);

pcs_word_t word_d;
pcs_word_t word_q;
logic      is_term;
int        term_n;

always_comb begin
	word_d  = WORD_IDLE;
	is_term = 1'b0;
	term_n  = 0;
	if (!lock_i) begin
		word_d = WORD_IDLE;
	end else if (!hdr_ok_i) begin
		word_d = WORD_ERR;
	end else if (block_i.sync == SYNC_DATA) begin
		word_d.ctrl = 1'b0;
		word_d.idle = 1'b0;
		word_d.keep = '1;
		word_d.data = block_i.payload;
	end else begin
		case (block_i.payload[7:0])
			BT_IDLE: begin
				if (block_i.payload[63:8] == {8{CODE_IDLE}})
					word_d = WORD_IDLE;
				else
					word_d = WORD_ERR;
			end
			// lane 0 carries the start character, data follows in lanes 1 to 7.
			BT_START0: begin
				word_d.idle  = 1'b0;
				word_d.start = 2'b01;
				word_d.keep  = 8'hFE;
				word_d.data  = {block_i.payload[63:8], 8'h00};
			end
			// lanes 0 to 3 are control, the O field is not used here.
			BT_START4: begin
				word_d.idle  = 1'b0;
				word_d.start = 2'b10;
				word_d.keep  = 8'hE0;
				word_d.data  = {block_i.payload[63:40], 40'h0};
			end
			BT_TERM0: begin is_term = 1'b1; term_n = 0; end
			BT_TERM1: begin is_term = 1'b1; term_n = 1; end
			BT_TERM2: begin is_term = 1'b1; term_n = 2; end
			BT_TERM3: begin is_term = 1'b1; term_n = 3; end
			BT_TERM4: begin is_term = 1'b1; term_n = 4; end
			BT_TERM5: begin is_term = 1'b1; term_n = 5; end
			BT_TERM6: begin is_term = 1'b1; term_n = 6; end
			BT_TERM7: begin is_term = 1'b1; term_n = 7; end
			default:  word_d = WORD_ERR;
		endcase

		// data bytes of a terminate block follow the type byte.
		if (is_term) begin
			word_d.idle = 1'b0;
			word_d.term = 1'b1;
			for (int k = 0; k < KEEP_W-1; k++) begin
				if (k < term_n) begin
					word_d.keep[k]       = 1'b1;
					word_d.data[8*k +: 8] = block_i.payload[8+8*k +: 8];
				end
			end
		end
	end
end

always_ff @(posedge tx_par_clk) begin
	if (!nreset)
		word_q <= WORD_IDLE;
	else
		word_q <= word_d;
end

assign word_o = word_q;

endmodule

//--- hw/pcs_descrambler.sv
// self-synchronizing descrambler for the 64-bit block payload.
// the sync header passes through unchanged with the same delay.

`timescale 1ns/1ps

module pcs_descrambler
	import pcs_line_pkg::*;
(
	input  logic       tx_par_clk,
	input  logic       nreset,
	input  pcs_block_t block_i,
	output pcs_block_t block_o
);

// last received scrambled bits, the newest one at the top.
logic [SCR_W-1:0]           state_q;
logic [SCR_W+PAYLOAD_W-1:0] ext;
logic [PAYLOAD_W-1:0]       plain;
pcs_block_t                 block_q;

// bit i of the payload sits at ext[SCR_W+i], so taps are a fixed distance below it.
always_comb begin
	ext = {block_i.payload, state_q};
	for (int i = 0; i < PAYLOAD_W; i++)
		plain[i] = ext[SCR_W+i] ^ ext[SCR_W-SCR_TAP+i] ^ ext[i];
end

always_ff @(posedge tx_par_clk) begin
	if (!nreset)
		state_q <= '0;
	else
		state_q <= block_i.payload[PAYLOAD_W-1 -: SCR_W];
end

always_ff @(posedge tx_par_clk) begin
	block_q.sync    <= block_i.sync;
	block_q.payload <= plain;
end

assign block_o = block_q;

endmodule

//--- hw/pcs_line_pkg.sv
// line coding definitions for the 10GBASE-R PCS.
// holds sync headers, block types, control codes, lock thresholds,
// scrambler constants and the 66-bit block struct.

package pcs_line_pkg;

	// ******************************
	// block framing
	// ******************************
	localparam int PAYLOAD_W = 64;

	localparam logic [1:0] SYNC_DATA = 2'b01;
	localparam logic [1:0] SYNC_CTRL = 2'b10;

	// 7-bit control codes carried in control lanes.
	localparam logic [6:0] CODE_IDLE  = 7'h00;
	localparam logic [6:0] CODE_ERROR = 7'h1E;

	// block type field, found in the lowest payload byte of a control block.
	typedef enum logic [7:0] {
		BT_IDLE   = 8'h1E,
		BT_START0 = 8'h78,
		BT_START4 = 8'h33,
		BT_TERM0  = 8'h87,
		BT_TERM1  = 8'h99,
		BT_TERM2  = 8'hAA,
		BT_TERM3  = 8'hB4,
		BT_TERM4  = 8'hCC,
		BT_TERM5  = 8'hD2,
		BT_TERM6  = 8'hE1,
		BT_TERM7  = 8'hFF
	} block_type_e;

	typedef struct packed {
		logic [1:0]           sync;
		logic [PAYLOAD_W-1:0] payload;
	} pcs_block_t;

	// an unscrambled block of eight idle lanes.
	localparam pcs_block_t BLOCK_IDLE = '{sync: SYNC_CTRL, payload: {56'h0, BT_IDLE}};

	// ******************************
	// block lock and scrambler
	// ******************************
	localparam int LOCK_GOOD_CNT = 64;
	localparam int LOCK_BAD_CNT  = 16;
	localparam int LOCK_WIN      = 64;
	localparam int LOCK_GOOD_W   = $clog2(LOCK_GOOD_CNT);
	localparam int LOCK_BAD_W    = $clog2(LOCK_BAD_CNT);
	localparam int LOCK_WIN_W    = $clog2(LOCK_WIN);

	// polynomial x^58 + x^39 + 1.
	localparam int SCR_W   = 58;
	localparam int SCR_TAP = 39;

endpackage

//--- hw/pcs_rx.sv
// receive path of the PCS.
// block lock and descrambler see the same input, the decoder merges them.

`timescale 1ns/1ps

module pcs_rx
	import pcs_line_pkg::*;
	import pcs_word_pkg::*;
(
	input  logic       tx_par_clk,
	input  logic       nreset,
	input  logic       serdes_lock_i,
	input  pcs_block_t serdes_block_i,
	output logic       lock_o,
	output pcs_word_t  word_o
);

logic       blk_lock;
logic       hdr_ok;
pcs_block_t plain_block;

pcs_block_lock u_block_lock (
	.tx_par_clk    (tx_par_clk),
	.nreset        (nreset),
	.serdes_lock_i (serdes_lock_i),
	.block_i       (serdes_block_i),
	.hdr_ok_o      (hdr_ok),
	.lock_o        (blk_lock)
);

pcs_descrambler u_descrambler (
	.tx_par_clk (tx_par_clk),
	.nreset     (nreset),
	.block_i    (serdes_block_i),
	.block_o    (plain_block)
);

// lock, hdr_ok and plain_block are all one cycle behind the input.
pcs_decoder u_decoder (
	.tx_par_clk (tx_par_clk),
	.nreset     (nreset),
	.lock_i     (blk_lock),
	.hdr_ok_i   (hdr_ok),
	.block_i    (plain_block),
	.word_o     (word_o)
);

assign lock_o = blk_lock;

endmodule

//--- hw/pcs_tx.sv
// transmit path of the PCS.
// encodes a client word into a 66-bit block, then scrambles the payload.

`timescale 1ns/1ps

module pcs_tx
	import pcs_line_pkg::*;
	import pcs_word_pkg::*;
(
	input  logic       tx_par_clk,
	input  logic       nreset,
	input  pcs_word_t  word_i,
	output pcs_block_t serdes_block_o
);

pcs_block_t                 enc_d;
pcs_block_t                 enc_q;
pcs_block_t                 out_q;
block_type_e                term_type;
logic [55:0]                term_data;
int                         nbytes;
logic [SCR_W-1:0]           scr_q;
logic [SCR_W+PAYLOAD_W-1:0] ext;

// ******************************
// encoder
// ******************************
always_comb begin
	nbytes    = $countones(word_i.keep);
	term_data = '0;
	case (nbytes)
		0:       term_type = BT_TERM0;
		1:       term_type = BT_TERM1;
		2:       term_type = BT_TERM2;
		3:       term_type = BT_TERM3;
		4:       term_type = BT_TERM4;
		5:       term_type = BT_TERM5;
		6:       term_type = BT_TERM6;
		default: term_type = BT_TERM7;
	endcase
	// codes after the last data byte stay zero.
	for (int k = 0; k < KEEP_W-1; k++) begin
		if (k < nbytes)
			term_data[8*k +: 8] = word_i.data[8*k +: 8];
	end

	enc_d.sync = SYNC_CTRL;
	if (word_i.err)
		enc_d.payload = {{8{CODE_ERROR}}, BT_IDLE};
	else if (word_i.idle)
		enc_d.payload = {{8{CODE_IDLE}}, BT_IDLE};
	else if (word_i.start[0])
		enc_d.payload = {word_i.data[63:8], BT_START0};
	else if (word_i.start[1])
		enc_d.payload = {word_i.data[63:40], 4'h0, {4{CODE_IDLE}}, BT_START4};
	else if (word_i.term)
		enc_d.payload = {term_data, term_type};
	else begin
		enc_d.sync    = SYNC_DATA;
		enc_d.payload = word_i.data;
	end
end

// ******************************
// scrambler
// ******************************
// each output bit feeds the taps of later bits, so the loop runs from bit 0 up.
always_comb begin
	ext = {{PAYLOAD_W{1'b0}}, scr_q};
	for (int i = 0; i < PAYLOAD_W; i++)
		ext[SCR_W+i] = enc_q.payload[i] ^ ext[SCR_W-SCR_TAP+i] ^ ext[i];
end

// in reset the line sees plain idle blocks.
always_ff @(posedge tx_par_clk) begin
	if (!nreset) begin
		enc_q <= BLOCK_IDLE;
		out_q <= BLOCK_IDLE;
		scr_q <= '0;
	end else begin
		enc_q         <= enc_d;
		scr_q         <= ext[SCR_W+PAYLOAD_W-1 -: SCR_W];
		out_q.sync    <= enc_q.sync;
		out_q.payload <= ext[SCR_W +: PAYLOAD_W];
	end
end

assign serdes_block_o = out_q;

endmodule

//--- hw/pcs_word_pkg.sv
// client side definitions for the PCS loopback.
// holds the data widths and the decoded word struct with its constant words.

package pcs_word_pkg;

	localparam int DATA_W  = 64;
	localparam int KEEP_W  = DATA_W/8;
	localparam int START_W = 2;

	// decoded client word, 78 bits wide.
	typedef struct packed {
		logic               ctrl;
		logic               idle;
		logic [START_W-1:0] start;
		logic               term;
		logic               err;
		logic [KEEP_W-1:0]  keep;
		logic [DATA_W-1:0]  data;
	} pcs_word_t;

	localparam pcs_word_t WORD_IDLE = '{ctrl: 1'b1, idle: 1'b1, start: '0, term: 1'b0,
		err: 1'b0, keep: '0, data: '0};
	localparam pcs_word_t WORD_ERR  = '{ctrl: 1'b1, idle: 1'b0, start: '0, term: 1'b0,
		err: 1'b1, keep: '0, data: '0};

endpackage

//--- run_sim.sh
#!/bin/sh
# build the PCS loopback testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sources.f --top-module pcs_loopback_tb
out=$(./obj_dir/Vpcs_loopback_tb 2>&1 || true)
echo "$out"
echo "$out" | grep -qx "No errors"

//--- sources.f
hw/pcs_line_pkg.sv
hw/pcs_word_pkg.sv
hw/pcs_block_lock.sv
hw/pcs_descrambler.sv
hw/pcs_decoder.sv
hw/pcs_rx.sv
hw/pcs_tx.sv
hw/pcs_10g_loopback.sv
tb/pcs_loopback_tb.sv

//--- tb/pcs_loopback_tb.sv
// testbench for the 10GBASE-R PCS loopback.
// drives scrambled random blocks, models block lock and the decode and
// encode rules, and checks the lock flag and the descrambled tx blocks.

`timescale 1ns/1ps

module pcs_loopback_tb
	import pcs_line_pkg::*;
();

localparam int N_BLOCKS    = 1500;
localparam int CYCLE_LIMIT = N_BLOCKS + 6 + 200;
localparam logic [7:0] TERM_TYPES [8] = '{8'h87, 8'h99, 8'hAA, 8'hB4,
	8'hCC, 8'hD2, 8'hE1, 8'hFF};
localparam pcs_block_t IDLE_BLOCK = '{sync: 2'b10, payload: {56'h0, 8'h1E}};
localparam pcs_block_t ERR_BLOCK  = '{sync: 2'b10, payload: {{8{7'h1E}}, 8'h1E}};

logic       tx_par_clk;
logic       nreset;
logic       rx_locked_i;
pcs_block_t rx_par_data_i;
logic       rx_block_lock_o;
pcs_block_t tx_par_data_o;

integer           seed;
logic [SCR_W-1:0] scr_st;
logic [SCR_W-1:0] dscr_st;
logic             model_lock;
int               good_cnt;
int               bad_cnt;
int               win_cnt;
int               cycles;
pcs_block_t       exp_q[$];
logic             lock_q[$];

pcs_10g_loopback u_dut (
	.tx_par_clk      (tx_par_clk),
	.nreset          (nreset),
	.rx_locked_i     (rx_locked_i),
	.rx_par_data_i   (rx_par_data_i),
	.rx_block_lock_o (rx_block_lock_o),
	.tx_par_data_o   (tx_par_data_o)
);

initial begin
	tx_par_clk = 1'b0;
	forever #50 tx_par_clk = ~tx_par_clk;
end

// ******************************
// line model
// ******************************
function automatic logic [63:0] scramble_payload(input logic [63:0] d);
	logic [63:0] q;
	for (int i = 0; i < 64; i++) begin
		q[i]   = d[i] ^ scr_st[SCR_TAP-1] ^ scr_st[SCR_W-1];
		scr_st = {scr_st[SCR_W-2:0], q[i]};
	end
	return q;
endfunction

// the descrambler is self-synchronizing, so one block after a mismatch its state is right again.
function automatic logic [63:0] descramble_payload(input logic [63:0] d);
	logic [63:0] q;
	for (int i = 0; i < 64; i++) begin
		q[i]    = d[i] ^ dscr_st[SCR_TAP-1] ^ dscr_st[SCR_W-1];
		dscr_st = {dscr_st[SCR_W-2:0], d[i]};
	end
	return q;
endfunction

function automatic pcs_block_t make_block(input int k);
	pcs_block_t  b;
	logic [63:0] rnd;
	logic [31:0] r;
	int          n;
	rnd    = {$random(seed), $random(seed)};
	r      = $random(seed);
	n      = int'(r[6:4]);
	b.sync = 2'b10;
	case (r[3:0])
		4'd6, 4'd7, 4'd8: b.payload = {56'h0, 8'h1E};
		4'd9: begin
			b.payload              = {56'h0, 8'h1E};
			b.payload[8+7*n +: 7] = 7'h1E;
		end
		4'd10: b.payload = {rnd[63:8], 8'h78};
		4'd11: b.payload = {rnd[63:40], 32'h0, 8'h33};
		4'd12, 4'd13: begin
			b.payload = {56'h0, TERM_TYPES[n]};
			for (int i = 0; i < n; i++)
				b.payload[8+8*i +: 8] = rnd[8*i +: 8];
		end
		// the ordered set types are not supported by this PCS.
		4'd14: b.payload = {rnd[63:8], r[7] ? 8'h4B : 8'h2D};
		default: begin
			b.sync    = 2'b01;
			b.payload = rnd;
		end
	endcase
	// a burst of bad headers sits in the middle and rare single ones occur elsewhere.
	if ((k >= 1100 && k < 1140) || (k >= 100 && r[31:25] == 7'd0))
		b.sync = r[8] ? 2'b11 : 2'b00;
	return b;
endfunction

// the block that comes back after decoding and encoding again.
function automatic pcs_block_t expected_block(input pcs_block_t b);
	pcs_block_t e;
	e = b;
	if (b.sync == 2'b10) begin
		e = ERR_BLOCK;
		if (b.payload[7:0] == 8'h1E && b.payload[63:8] == '0)
			e = b;
		if (b.payload[7:0] == 8'h78)
			e = b;
		if (b.payload[7:0] == 8'h33)
			e.payload = {b.payload[63:40], 32'h0, 8'h33};
		for (int n = 0; n < 8; n++) begin
			if (b.payload[7:0] == TERM_TYPES[n]) begin
				e.payload = {56'h0, TERM_TYPES[n]};
				for (int i = 0; i < n; i++)
					e.payload[8+8*i +: 8] = b.payload[8+8*i +: 8];
			end
		end
	end else if (b.sync != 2'b01) begin
		e = ERR_BLOCK;
	end
	return e;
endfunction

task automatic step_lock_model(input logic hdr_ok, input logic link);
	if (!link) begin
		model_lock = 1'b0;
		good_cnt   = 0;
		bad_cnt    = 0;
		win_cnt    = 0;
	end else if (!model_lock) begin
		good_cnt = hdr_ok ? good_cnt + 1 : 0;
		if (good_cnt == 64) begin
			model_lock = 1'b1;
			good_cnt   = 0;
			bad_cnt    = 0;
			win_cnt    = 0;
		end
	end else begin
		if (!hdr_ok)
			bad_cnt++;
		if (bad_cnt == 16) begin
			model_lock = 1'b0;
			bad_cnt    = 0;
			win_cnt    = 0;
		end else if (win_cnt == 63) begin
			bad_cnt = 0;
			win_cnt = 0;
		end else begin
			win_cnt++;
		end
	end
endtask

task automatic check_value(input logic [65:0] got, input logic [65:0] exp, input string what);
	if (got !== exp) begin
		$display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		$display("Errors found");
		$fatal(1, "simulation stopped on a mismatch");
	end
endtask

// ******************************
// stimulus and checks
// ******************************
initial begin
	pcs_block_t blk;
	pcs_block_t got;
	logic       link;
	seed          = 32'h49ef_7968;
	nreset        = 1'b0;
	rx_locked_i   = 1'b1;
	rx_par_data_i = IDLE_BLOCK;
	scr_st        = '0;
	dscr_st       = '0;
	model_lock    = 1'b0;
	good_cnt      = 0;
	bad_cnt       = 0;
	win_cnt       = 0;
	lock_q.push_back(1'b0);
	@(posedge tx_par_clk);
	for (int k = 0; k < N_BLOCKS + 5; k++) begin
		@(posedge tx_par_clk);
		nreset <= 1'b1;
		if (k < N_BLOCKS) begin
			blk  = make_block(k);
			link = !(k >= 1300 && k < 1310);
			rx_locked_i   <= link;
			rx_par_data_i <= '{sync: blk.sync, payload: scramble_payload(blk.payload)};
			step_lock_model(blk.sync == 2'b01 || blk.sync == 2'b10, link);
			lock_q.push_back(model_lock);
			exp_q.push_back(model_lock ? expected_block(blk) : IDLE_BLOCK);
		end
		@(negedge tx_par_clk);
		got         = tx_par_data_o;
		got.payload = descramble_payload(tx_par_data_o.payload);
		if (k <= N_BLOCKS)
			check_value(66'(rx_block_lock_o), 66'(lock_q[k]), "block lock");
		// the tx side is still held in reset for the first cycles.
		if (k <= 3)
			check_value(tx_par_data_o, IDLE_BLOCK, "raw idle block in tx reset");
		else if (k >= 5)
			check_value(got, exp_q.pop_front(), "descrambled tx block");
	end
	$display("No errors");
	$finish;
end

initial begin
	cycles = 0;
	while (cycles <= CYCLE_LIMIT) begin
		@(posedge tx_par_clk);
		cycles++;
	end
	$display("timeout: the run went past the limit of %0d cycles", CYCLE_LIMIT);
	$display("Errors found");
	$fatal(1, "run stopped by the cycle limit");
end

endmodule
